// ==== compile.f ====
logic/ren_pkg.sv
logic/isq_slots.sv
logic/ren_line.sv
logic/ren_seg_ctrl.sv
logic/ren_matrix.sv
logic/ren_top.sv
test/ren_chk.sv
test/ren_tb.sv

// ==== Bender.yml ====
package:
  name: ren_matrix

sources:
  - files:
      - logic/ren_pkg.sv
      - logic/isq_slots.sv
      - logic/ren_line.sv
      - logic/ren_seg_ctrl.sv
      - logic/ren_matrix.sv
      - logic/ren_top.sv
  - target: test
    files:
      - test/ren_chk.sv
      - test/ren_tb.sv

// ==== test/ren_tb.sv ====
//////////////////////////////////////////////////
// testbench of the rename top level
// clock, reset and dispatch / resolve / writeback drivers
// reference rename model with per-cycle compare
// directed and random tests, watchdog, report
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ren_tb;
   import ren_pkg::*;

   localparam int NUM_TESTS    = 6;
   localparam int CYC_PER_TEST = 200;
   localparam int CLK_PERIOD   = 10;

   logic         clk;
   logic         rst_n;
   logic         dsp_req;
   isq_inst_t    dsp_inst;
   logic         dsp_ack;
   logic         resolve_vld;
   slot_idx_t    resolve_idx;
   logic         wb_vld;
   preg_t        wb_preg;
   ren_out_vec_t ren_out;
   logic         isq_ful;

   // model of the queue state, updated on every rising edge
   isq_inst_t            m_inst [ISQ_DEPTH];
   logic [ISQ_DEPTH-1:0] m_vld;
   logic [ISQ_DEPTH-1:0] m_wat;
   logic [ISQ_DEPTH-1:0] m_drdy;
   slot_idx_t            m_wptr;
   logic [1:0]           m_occ;
   logic                 m_arch;
   logic                 m_ack;
   ren_map_t             m_commit;

   logic [31:0] rng_q;
   int          errors;

   ren_top i_ren_top (
      .clk           (clk),
      .rst_n         (rst_n),
      .dsp_req_i     (dsp_req),
      .dsp_inst_i    (dsp_inst),
      .dsp_ack_o     (dsp_ack),
      .resolve_vld_i (resolve_vld),
      .resolve_idx_i (resolve_idx),
      .wb_vld_i      (wb_vld),
      .wb_preg_i     (wb_preg),
      .ren_out_o     (ren_out),
      .isq_ful_o     (isq_ful)
   );

   bind ren_top ren_chk i_ren_chk (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   //////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////

   function automatic ren_map_t identity_map();
      ren_map_t map;
      for (int i = 0; i < NUM_LREG; i++)
      begin
         map[i] = '{rdy: 1'b1, preg: preg_t'(i)};
      end
      return map;
   endfunction

   // map after walking the older segment from the committed map
   function automatic ren_map_t older_end_map();
      ren_map_t map;
      int       s;
      map = m_commit;
      for (int k = 0; k < SEG_DEPTH; k++)
      begin
         s = m_arch * SEG_DEPTH + k;
         if (m_vld[s] && m_inst[s].dst_vld)
         begin
            map[m_inst[s].ldst] = '{rdy: m_drdy[s], preg: m_inst[s].pdest};
         end
      end
      return map;
   endfunction

   // expected outputs, oldest slot first
   function automatic ren_out_vec_t ren_model();
      ren_out_vec_t exp;
      ren_map_t     map;
      isq_inst_t    in;
      map_ent_t     e1;
      map_ent_t     e2;
      int           s;
      exp = '0;
      map = m_commit;
      for (int k = 0; k < ISQ_DEPTH; k++)
      begin
         s  = (k + (m_arch ? SEG_DEPTH : 0)) % ISQ_DEPTH;
         in = m_inst[s];
         if (m_vld[s])
         begin
            e1 = map[in.lsrc1];
            e2 = map[in.lsrc2];
            exp[k].vld      = 1'b1;
            exp[k].src1_vld = in.src1_vld;
            exp[k].src2_vld = in.src2_vld;
            exp[k].dst_vld  = in.dst_vld;
            exp[k].inst_rdy = (!in.src1_vld || e1.rdy) && (!in.src2_vld || e2.rdy);
            if (in.src1_vld)
               exp[k].psrc1 = e1;
            if (in.src2_vld)
               exp[k].psrc2 = e2;
            if (in.dst_vld)
            begin
               exp[k].pdest    = in.pdest;
               exp[k].fre_preg = map[in.ldst].preg;
               map[in.ldst]    = '{rdy: m_drdy[s], preg: in.pdest};
            end
         end
      end
      return exp;
   endfunction

   //////////////////////////////////////////////////
   // compare and model step
   //////////////////////////////////////////////////

   always @(posedge clk or negedge rst_n)
   begin
      ren_out_vec_t exp;
      ren_map_t     endm;
      logic         full;
      logic         wr_en;
      logic         done;
      logic         retire;
      int           older;
      if (!rst_n)
      begin
         m_vld    = '0;
         m_wat    = '0;
         m_drdy   = '0;
         m_wptr   = '0;
         m_occ    = '0;
         m_arch   = 1'b0;
         m_ack    = 1'b0;
         m_commit = identity_map();
      end
      else
      begin
         // outputs still show the state before this edge
         exp = ren_model();
         for (int k = 0; k < ISQ_DEPTH; k++)
         begin
            assert (ren_out[k] == exp[k])
            else
            begin
               $display("mismatch ren_out_o[%0d] got %h exp %h", k, ren_out[k], exp[k]);
               errors++;
            end
         end
         older = m_arch;
         full  = (m_wptr[1:0] == 2'b00) && m_occ[m_wptr[2]];
         wr_en = dsp_req && !m_ack && !full;
         assert (isq_ful == full)
         else
         begin
            $display("mismatch isq_ful_o got %h exp %h", isq_ful, full);
            errors++;
         end
         assert (dsp_ack == m_ack)
         else
         begin
            $display("mismatch dsp_ack_o got %h exp %h", dsp_ack, m_ack);
            errors++;
         end
         // older segment retires once resolved, left by the pointer or
         // blocking a full ring, and ready
         endm = older_end_map();
         done = 1'b1;
         for (int k = 0; k < SEG_DEPTH; k++)
         begin
            if (m_vld[older*SEG_DEPTH+k] && m_wat[older*SEG_DEPTH+k])
               done = 1'b0;
         end
         retire = done && ((m_wptr[2] != m_arch) || full);
         for (int i = 0; i < NUM_LREG; i++)
         begin
            retire &= endm[i].rdy;
         end
         for (int i = 0; i < ISQ_DEPTH; i++)
         begin
            if (wr_en && (m_wptr == slot_idx_t'(i)))
               m_drdy[i] = 1'b0;
            else if (wb_vld && m_vld[i] && (m_inst[i].pdest == wb_preg))
               m_drdy[i] = 1'b1;
         end
         for (int i = 0; i < ISQ_DEPTH; i++)
         begin
            if (wr_en && (m_wptr == slot_idx_t'(i)))
            begin
               m_inst[i] = dsp_inst;
               m_vld[i]  = 1'b1;
               m_wat[i]  = dsp_inst.wat;
            end
            else if (retire && (i / SEG_DEPTH == older))
            begin
               m_vld[i] = 1'b0;
               m_wat[i] = 1'b0;
            end
            else if (resolve_vld && (resolve_idx == slot_idx_t'(i)))
               m_wat[i] = 1'b0;
         end
         for (int s = 0; s < 2; s++)
         begin
            if (retire && (s == older))
               m_occ[s] = 1'b0;
            else if (wr_en && (m_wptr[2] == s[0]))
               m_occ[s] = 1'b1;
         end
         if (wr_en)
            m_ack = 1'b1;
         else if (!dsp_req)
            m_ack = 1'b0;
         m_wptr = m_wptr + wr_en;
         if (retire)
         begin
            m_commit = endm;
            m_arch   = !m_arch;
         end
      end
   end

   //////////////////////////////////////////////////
   // stimulus helpers
   //////////////////////////////////////////////////

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_q;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      rng_q = x;
      return x;
   endfunction

   // directed ones wait, read dep_reg and write a destination
   function automatic isq_inst_t make_inst(logic directed, lreg_t dep_reg);
      isq_inst_t   in;
      logic [31:0] r;
      r = next_rand();
      in.vld      = 1'b1;
      in.wat      = directed | r[0];
      in.src1_vld = directed | r[1];
      in.lsrc1    = directed ? dep_reg : r[4:2];
      in.src2_vld = r[5];
      in.lsrc2    = r[8:6];
      in.dst_vld  = directed | r[9];
      in.ldst     = r[12:10];
      in.pdest    = r[17:13];
      return in;
   endfunction

   task automatic apply_reset();
      @(negedge clk);
      rst_n       = 1'b0;
      dsp_req     = 1'b0;
      resolve_vld = 1'b0;
      wb_vld      = 1'b0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
   endtask

   task automatic dispatch(isq_inst_t inst);
      @(negedge clk);
      dsp_req  = 1'b1;
      dsp_inst = inst;
      @(negedge clk);
      while (!dsp_ack)
         @(negedge clk);
      dsp_req = 1'b0;
      @(negedge clk);
      while (dsp_ack)
         @(negedge clk);
   endtask

   task automatic resolve_slot(slot_idx_t idx);
      @(negedge clk);
      resolve_vld = 1'b1;
      resolve_idx = idx;
      @(negedge clk);
      resolve_vld = 1'b0;
   endtask

   task automatic write_back(preg_t preg);
      @(negedge clk);
      wb_vld  = 1'b1;
      wb_preg = preg;
      @(negedge clk);
      wb_vld = 1'b0;
   endtask

   // resolve and write back the older segment, then wait for its retire
   task automatic drain_older();
      int seg;
      int s;
      seg = m_arch;
      for (int k = 0; k < SEG_DEPTH; k++)
      begin
         s = seg * SEG_DEPTH + k;
         if (m_vld[s] && m_wat[s])
            resolve_slot(slot_idx_t'(s));
         if (m_vld[s])
            write_back(m_inst[s].pdest);
      end
      while (m_occ[seg])
         @(negedge clk);
   endtask

   task automatic check(logic ok, string what);
      assert (ok)
      else
      begin
         $display("check failed: %s", what);
         errors++;
      end
   endtask

   task automatic report_test(int num, string name, int err_start);
      if (errors == err_start)
         $display("test %0d %s: ok", num, name);
      else
         $display("test %0d %s: %0d errors", num, name, errors - err_start);
   endtask

   //////////////////////////////////////////////////
   // watchdog
   //////////////////////////////////////////////////

   initial
   begin
      #(NUM_TESTS * CYC_PER_TEST * CLK_PERIOD);
      $display("timeout: tests did not finish in %0d cycles", NUM_TESTS * CYC_PER_TEST);
      $display("Simulation failed");
      $finish;
   end

   //////////////////////////////////////////////////
   // tests
   //////////////////////////////////////////////////

   initial
   begin
      isq_inst_t    in;
      isq_inst_t    prev;
      ren_out_vec_t snap;
      logic [31:0]  r;
      int           e0;
      clk         = 1'b0;
      rst_n       = 1'b0;
      dsp_req     = 1'b0;
      dsp_inst    = '0;
      resolve_vld = 1'b0;
      resolve_idx = '0;
      wb_vld      = 1'b0;
      wb_preg     = '0;
      errors      = 0;
      rng_q       = 32'hecfc9f7a;

      // 1: empty after reset
      e0 = errors;
      apply_reset();
      @(negedge clk);
      for (int k = 0; k < ISQ_DEPTH; k++)
         check(!ren_out[k].vld, "output entry valid after reset");
      check(!isq_ful && !dsp_ack, "full or ack high after reset");
      report_test(1, "reset", e0);

      // 2: chain of four dependent instructions
      e0   = errors;
      prev = make_inst(1'b1, 3'd0);
      dispatch(prev);
      for (int n = 1; n < SEG_DEPTH; n++)
      begin
         in = make_inst(1'b1, prev.ldst);
         dispatch(in);
         prev = in;
      end
      report_test(2, "rename chain", e0);

      // 3: writebacks wake up dependent sources
      e0 = errors;
      write_back(m_inst[0].pdest);
      @(negedge clk);
      check(ren_out[1].psrc1.rdy, "source of slot 1 not ready after writeback");
      write_back(m_inst[1].pdest);
      @(negedge clk);
      check(ren_out[2].psrc1.rdy, "source of slot 2 not ready after writeback");
      report_test(3, "readiness", e0);

      // 4: fill the ring, a ninth request stalls and stays pending
      e0 = errors;
      for (int n = 0; n < SEG_DEPTH; n++)
      begin
         in = make_inst(1'b1, prev.ldst);
         dispatch(in);
         prev = in;
      end
      check(isq_ful, "queue not full after eight dispatches");
      snap = ren_out;
      dsp_req  = 1'b1;
      dsp_inst = make_inst(1'b1, prev.ldst);
      repeat (6) @(negedge clk);
      check(!dsp_ack, "ninth request acked while full");
      check(ren_out == snap, "outputs changed while stalled");
      report_test(4, "back-pressure", e0);

      // 5: retire the lower half, the held request then lands in slot 0
      e0 = errors;
      in = dsp_inst;
      drain_older();
      while (!dsp_ack)
         @(negedge clk);
      dsp_req = 1'b0;
      @(negedge clk);
      while (dsp_ack)
         @(negedge clk);
      for (int k = 0; k < SEG_DEPTH; k++)
      begin
         check(ren_out[k].vld && (ren_out[k].pdest == m_inst[k+SEG_DEPTH].pdest),
               "upper slot not reordered to low index");
      end
      check(ren_out[SEG_DEPTH].vld && (ren_out[SEG_DEPTH].pdest == in.pdest),
            "held instruction not at index 4");
      check(ren_out[SEG_DEPTH].psrc1.preg == prev.pdest,
            "held instruction did not rename across the ring");
      check(!ren_out[SEG_DEPTH+1].vld, "freed slot still valid");
      apply_reset();
      report_test(5, "retire and reorder", e0);

      // 6: random traffic, drained before the ring would fill
      e0 = errors;
      for (int n = 0; n < 40; n++)
      begin
         in = make_inst(1'b0, 3'd0);
         if ((m_wptr[1:0] == 2'b11) && m_occ[!m_wptr[2]])
            drain_older();
         dispatch(in);
         r = next_rand();
         if (r[0])
            resolve_slot(slot_idx_t'(r[3:1]));
         if (r[4])
            write_back(r[5] ? m_inst[r[8:6]].pdest : preg_t'(r[13:9]));
      end
      @(negedge clk);
      report_test(6, "random run", e0);

      $display("tests: %0d, errors: %0d", NUM_TESTS, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// ==== test/ren_chk.sv ====
//////////////////////////////////////////////////
// bound checker for the rename top level
// dispatch handshake rules
// empty outputs right after reset
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ren_chk
   import ren_pkg::*;
(
   input logic         clk,
   input logic         rst_n,
   input logic         dsp_req_i,
   input logic         dsp_ack_o,
   input logic         isq_ful_o,
   input ren_out_vec_t ren_out_o
);

   logic [ISQ_DEPTH-1:0] out_vld;

   // valid bit of every output entry
   always_comb
   begin
      for (int i = 0; i < ISQ_DEPTH; i++)
      begin
         out_vld[i] = ren_out_o[i].vld;
      end
   end

   // a full queue takes no instruction, so ack stays low
   ack_not_when_full: assert property (@(posedge clk) disable iff (!rst_n)
      (isq_ful_o && !dsp_ack_o) |=> !dsp_ack_o)
      else $error("ack rose while the queue was full");

   // four-phase: ack drops only once req is gone
   ack_fall_after_req: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(dsp_ack_o) |-> $past(!dsp_req_i))
      else $error("ack fell while req was still high");

   out_empty_after_reset: assert property (@(posedge clk)
      $rose(rst_n) |-> (out_vld == '0))
      else $error("output entries valid right after reset");

endmodule

// ==== logic/ren_top.sv ====
//////////////////////////////////////////////////
// top level of the rename block
// slot storage, segment control and rename matrix
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ren_top
   import ren_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         dsp_req_i,
   input  isq_inst_t    dsp_inst_i,
   output logic         dsp_ack_o,
   input  logic         resolve_vld_i,
   input  slot_idx_t    resolve_idx_i,
   input  logic         wb_vld_i,
   input  preg_t        wb_preg_i,
   output ren_out_vec_t ren_out_o,
   output logic         isq_ful_o
);

   isq_inst_t [ISQ_DEPTH-1:0] slots;
   logic [ISQ_DEPTH-1:0]      slot_load;
   logic [ISQ_DEPTH-1:0]      slot_vld;
   logic [ISQ_DEPTH-1:0]      slot_wat;
   slot_idx_t                 wr_ptr;
   logic [NUM_SEG-1:0]        seg_retire;
   logic                      arch;
   ren_map_t                  lo_hdr;
   ren_map_t                  hi_hdr;
   ren_map_t                  lo_end_map;
   ren_map_t                  hi_end_map;

   isq_slots i_isq_slots (
      .clk           (clk),
      .rst_n         (rst_n),
      .dsp_req_i     (dsp_req_i),
      .dsp_inst_i    (dsp_inst_i),
      .dsp_ack_o     (dsp_ack_o),
      .resolve_vld_i (resolve_vld_i),
      .resolve_idx_i (resolve_idx_i),
      .seg_retire_i  (seg_retire),
      .slots_o       (slots),
      .slot_load_o   (slot_load),
      .slot_vld_o    (slot_vld),
      .slot_wat_o    (slot_wat),
      .wr_ptr_o      (wr_ptr),
      .isq_ful_o     (isq_ful_o)
   );

   ren_seg_ctrl i_ren_seg_ctrl (
      .clk          (clk),
      .rst_n        (rst_n),
      .slot_vld_i   (slot_vld),
      .slot_wat_i   (slot_wat),
      .wr_ptr_i     (wr_ptr),
      .lo_end_map_i (lo_end_map),
      .hi_end_map_i (hi_end_map),
      .arch_o       (arch),
      .lo_hdr_o     (lo_hdr),
      .hi_hdr_o     (hi_hdr),
      .seg_retire_o (seg_retire)
   );

   ren_matrix i_ren_matrix (
      .clk          (clk),
      .rst_n        (rst_n),
      .slots_i      (slots),
      .slot_load_i  (slot_load),
      .wb_vld_i     (wb_vld_i),
      .wb_preg_i    (wb_preg_i),
      .arch_i       (arch),
      .lo_hdr_i     (lo_hdr),
      .hi_hdr_i     (hi_hdr),
      .lo_end_map_o (lo_end_map),
      .hi_end_map_o (hi_end_map),
      .ren_out_o    (ren_out_o)
   );

endmodule

// ==== logic/ren_matrix.sv ====
//////////////////////////////////////////////////
// rename matrix, one rename line per slot
// map chaining with header splice at segment heads
// oldest-first reordering of the line outputs
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ren_matrix
   import ren_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  isq_inst_t [ISQ_DEPTH-1:0] slots_i,
   input  logic [ISQ_DEPTH-1:0]      slot_load_i,
   input  logic                      wb_vld_i,
   input  preg_t                     wb_preg_i,
   input  logic                      arch_i,
   input  ren_map_t                  lo_hdr_i,
   input  ren_map_t                  hi_hdr_i,
   output ren_map_t                  lo_end_map_o,
   output ren_map_t                  hi_end_map_o,
   output ren_out_vec_t              ren_out_o
);

   ren_map_t     prv_map [ISQ_DEPTH];
   ren_map_t     cur_map [ISQ_DEPTH];
   ren_out_vec_t line_out;

   //////////////////////////////////////////////////
   // line chain
   //////////////////////////////////////////////////

   for (genvar i = 0; i < ISQ_DEPTH; i++)
   begin : g_line
      if (i == 0)
      begin : g_lo_head
         // lower head: committed map when lower half is older, else wrap from the top
         assign prv_map[i] = arch_i ? cur_map[ISQ_DEPTH-1] : lo_hdr_i;
      end
      else if (i == SEG_DEPTH)
      begin : g_hi_head
         // upper head: continue the chain, or start from its header when older
         assign prv_map[i] = arch_i ? hi_hdr_i : cur_map[SEG_DEPTH-1];
      end
      else
      begin : g_chain
         assign prv_map[i] = cur_map[i-1];
      end

      ren_line i_ren_line (
         .clk       (clk),
         .rst_n     (rst_n),
         .slot_i    (slots_i[i]),
         .load_i    (slot_load_i[i]),
         .wb_vld_i  (wb_vld_i),
         .wb_preg_i (wb_preg_i),
         .prv_map_i (prv_map[i]),
         .cur_map_o (cur_map[i]),
         .out_o     (line_out[i])
      );
   end

   // maps seen at the end of each segment, used for retire
   assign lo_end_map_o = cur_map[SEG_DEPTH-1];
   assign hi_end_map_o = cur_map[ISQ_DEPTH-1];

   //////////////////////////////////////////////////
   // reorder
   //////////////////////////////////////////////////

   // oldest segment lands on the low output indices
   always_comb
   begin
      for (int i = 0; i < ISQ_DEPTH; i++)
      begin
         ren_out_o[i] = line_out[(i + (arch_i ? SEG_DEPTH : 0)) % ISQ_DEPTH];
      end
   end

endmodule

// ==== logic/ren_seg_ctrl.sv ====
//////////////////////////////////////////////////
// segment control of the rename ring
// two committed map headers and the older segment bit
// retire condition and per segment retire pulses
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ren_seg_ctrl
   import ren_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [ISQ_DEPTH-1:0] slot_vld_i,
   input  logic [ISQ_DEPTH-1:0] slot_wat_i,
   input  slot_idx_t            wr_ptr_i,
   input  ren_map_t             lo_end_map_i,
   input  ren_map_t             hi_end_map_i,
   output logic                 arch_o,
   output ren_map_t             lo_hdr_o,
   output ren_map_t             hi_hdr_o,
   output logic [NUM_SEG-1:0]   seg_retire_o
);

   // arch_q is the index of the older segment, 0 = lower half
   logic               arch_q;
   ren_map_t           lo_hdr_q;
   ren_map_t           hi_hdr_q;
   logic [NUM_SEG-1:0] seg_done;
   logic [NUM_SEG-1:0] end_rdy;
   logic               ptr_seg;
   logic               ptr_park;
   logic               retire;

   // every logical register mapped to a written-back value
   function automatic logic map_all_rdy(ren_map_t map);
      logic rdy;
      rdy = 1'b1;
      for (int i = 0; i < NUM_LREG; i++)
      begin
         rdy &= map[i].rdy;
      end
      return rdy;
   endfunction

   //////////////////////////////////////////////////
   // retire condition
   //////////////////////////////////////////////////

   // segment done: no valid slot still waiting
   always_comb
   begin
      for (int s = 0; s < NUM_SEG; s++)
      begin
         seg_done[s] = &(~slot_vld_i[s*SEG_DEPTH +: SEG_DEPTH] |
                         ~slot_wat_i[s*SEG_DEPTH +: SEG_DEPTH]);
      end
   end

   assign end_rdy[0] = map_all_rdy(lo_end_map_i);
   assign end_rdy[1] = map_all_rdy(hi_end_map_i);

   // segment the write pointer currently fills
   assign ptr_seg    = wr_ptr_i[SLOT_W-1];

   // pointer parked on the head of an occupied older segment, ring full
   assign ptr_park   = (wr_ptr_i[SLOT_W-2:0] == '0) &&
                       (|slot_vld_i[arch_q*SEG_DEPTH +: SEG_DEPTH]);

   // older segment resolved, not being filled, all its results written back
   assign retire     = seg_done[arch_q] && ((ptr_seg != arch_q) || ptr_park) &&
                       end_rdy[arch_q];

   always_comb
   begin
      seg_retire_o         = '0;
      seg_retire_o[arch_q] = retire;
   end

   //////////////////////////////////////////////////
   // headers and arch
   //////////////////////////////////////////////////

   // the retiring segment's end map becomes the committed map
   // at the head of the segment that follows it
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         arch_q   <= 1'b0;
         lo_hdr_q <= RESET_MAP;
         hi_hdr_q <= RESET_MAP;
      end
      else if (retire)
      begin
         arch_q <= !arch_q;
         if (arch_q)
         begin
            lo_hdr_q <= hi_end_map_i;
         end
         else
         begin
            hi_hdr_q <= lo_end_map_i;
         end
      end
   end

   assign arch_o   = arch_q;
   assign lo_hdr_o = lo_hdr_q;
   assign hi_hdr_o = hi_hdr_q;

endmodule

// ==== logic/ren_line.sv ====
//////////////////////////////////////////////////
// one rename line of the matrix
// source lookup in the inherited map
// map update with the slot's destination
// destination ready tracking and freed register
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ren_line
   import ren_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  isq_inst_t slot_i,
   input  logic      load_i,
   input  logic      wb_vld_i,
   input  preg_t     wb_preg_i,
   input  ren_map_t  prv_map_i,
   output ren_map_t  cur_map_o,
   output ren_out_t  out_o
);

   logic     dst_rdy_q;
   logic     dst_upd;
   map_ent_t src1_ent;
   map_ent_t src2_ent;
   map_ent_t old_ent;
   logic     src1_ok;
   logic     src2_ok;

   //////////////////////////////////////////////////
   // destination ready
   //////////////////////////////////////////////////

   // a new slot write starts not ready, writeback of pdest sets it
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         dst_rdy_q <= 1'b0;
      end
      else if (load_i)
      begin
         dst_rdy_q <= 1'b0;
      end
      else if (wb_vld_i && slot_i.vld && (slot_i.pdest == wb_preg_i))
      begin
         dst_rdy_q <= 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // lookup and map update
   //////////////////////////////////////////////////

   assign src1_ent = prv_map_i[slot_i.lsrc1];
   assign src2_ent = prv_map_i[slot_i.lsrc2];
   // mapping overwritten by this line, freed once the line retires
   assign old_ent  = prv_map_i[slot_i.ldst];

   assign dst_upd  = slot_i.vld && slot_i.dst_vld;

   always_comb
   begin
      cur_map_o = prv_map_i;
      if (dst_upd)
      begin
         cur_map_o[slot_i.ldst].rdy  = dst_rdy_q;
         cur_map_o[slot_i.ldst].preg = slot_i.pdest;
      end
   end

   // unused sources never block issue
   assign src1_ok = !slot_i.src1_vld || src1_ent.rdy;
   assign src2_ok = !slot_i.src2_vld || src2_ent.rdy;

   //////////////////////////////////////////////////
   // output entry
   //////////////////////////////////////////////////

   always_comb
   begin
      out_o = '0;
      if (slot_i.vld)
      begin
         out_o.vld      = 1'b1;
         out_o.inst_rdy = src1_ok && src2_ok;
         out_o.src1_vld = slot_i.src1_vld;
         out_o.src2_vld = slot_i.src2_vld;
         out_o.dst_vld  = slot_i.dst_vld;
         if (slot_i.src1_vld)
         begin
            out_o.psrc1 = src1_ent;
         end
         if (slot_i.src2_vld)
         begin
            out_o.psrc2 = src2_ent;
         end
         if (slot_i.dst_vld)
         begin
            out_o.pdest    = slot_i.pdest;
            out_o.fre_preg = old_ent.preg;
         end
      end
   end

endmodule

// ==== logic/isq_slots.sv ====
//////////////////////////////////////////////////
// issue queue slot storage
// four-phase dispatch handshake and write pointer
// wait clearing on resolve
// segment occupancy, retire clearing, full flag
//////////////////////////////////////////////////

`timescale 1ns/1ps

module isq_slots
   import ren_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        dsp_req_i,
   input  isq_inst_t                   dsp_inst_i,
   output logic                        dsp_ack_o,
   input  logic                        resolve_vld_i,
   input  slot_idx_t                   resolve_idx_i,
   input  logic [NUM_SEG-1:0]          seg_retire_i,
   output isq_inst_t [ISQ_DEPTH-1:0]   slots_o,
   output logic [ISQ_DEPTH-1:0]        slot_load_o,
   output logic [ISQ_DEPTH-1:0]        slot_vld_o,
   output logic [ISQ_DEPTH-1:0]        slot_wat_o,
   output slot_idx_t                   wr_ptr_o,
   output logic                        isq_ful_o
);

   // payload storage, valid and wait kept apart so they can be reset
   isq_inst_t            mem_q [ISQ_DEPTH];
   logic [ISQ_DEPTH-1:0] vld_q;
   logic [ISQ_DEPTH-1:0] wat_q;
   slot_idx_t            wr_ptr_q;
   logic [NUM_SEG-1:0]   occ_q;
   logic                 ack_q;
   logic                 wr_seg;
   logic                 wr_en;

   //////////////////////////////////////////////////
   // dispatch handshake
   //////////////////////////////////////////////////

   // top pointer bit selects the segment
   assign wr_seg    = wr_ptr_q[SLOT_W-1];

   // full when the pointer is back at the head of a segment still in use
   assign isq_ful_o = (wr_ptr_q[SLOT_W-2:0] == '0) && occ_q[wr_seg];

   // one write per handshake, only while ack is still low
   assign wr_en     = dsp_req_i && !ack_q && !isq_ful_o;

   // one-hot write strobe, also clears the line's dest ready bit
   assign slot_load_o = {{(ISQ_DEPTH-1){1'b0}}, wr_en} << wr_ptr_q;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ack_q    <= 1'b0;
         wr_ptr_q <= '0;
      end
      else
      begin
         if (wr_en)
         begin
            ack_q    <= 1'b1;
            // wraps around the ring
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         else if (!dsp_req_i)
         begin
            // env released req, close the handshake
            ack_q <= 1'b0;
         end
      end
   end

   //////////////////////////////////////////////////
   // slot state
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem_q[wr_ptr_q] <= dsp_inst_i;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         vld_q <= '0;
         wat_q <= '0;
         occ_q <= '0;
      end
      else
      begin
         for (int i = 0; i < ISQ_DEPTH; i++)
         begin
            if (slot_load_o[i])
            begin
               vld_q[i] <= 1'b1;
               wat_q[i] <= dsp_inst_i.wat;
            end
            else if (seg_retire_i[i / SEG_DEPTH])
            begin
               // whole segment freed at once
               vld_q[i] <= 1'b0;
               wat_q[i] <= 1'b0;
            end
            else if (resolve_vld_i && (resolve_idx_i == slot_idx_t'(i)))
            begin
               wat_q[i] <= 1'b0;
            end
         end
         for (int s = 0; s < NUM_SEG; s++)
         begin
            // retire and write never hit the same segment
            if (seg_retire_i[s])
            begin
               occ_q[s] <= 1'b0;
            end
            else if (wr_en && (wr_seg == s[0]))
            begin
               occ_q[s] <= 1'b1;
            end
         end
      end
   end

   // stored payload with live valid and wait bits laid over it
   always_comb
   begin
      for (int i = 0; i < ISQ_DEPTH; i++)
      begin
         slots_o[i]     = mem_q[i];
         slots_o[i].vld = vld_q[i];
         slots_o[i].wat = wat_q[i];
      end
   end

   assign slot_vld_o = vld_q;
   assign slot_wat_o = wat_q;
   assign wr_ptr_o   = wr_ptr_q;
   assign dsp_ack_o  = ack_q;

endmodule

// ==== logic/ren_pkg.sv ====
//////////////////////////////////////////////////
// shared sizes of the rename matrix
// register and slot number types
// map entry, full rename map and its reset value
// issue queue slot and rename output formats
//////////////////////////////////////////////////

package ren_pkg;

   //////////////////////////////////////////////////
   // sizes
   //////////////////////////////////////////////////

   // issue queue slots, split into two segments
   localparam int ISQ_DEPTH = 8;
   localparam int SEG_DEPTH = 4;
   localparam int NUM_SEG   = ISQ_DEPTH / SEG_DEPTH;

   // register files
   localparam int NUM_LREG  = 8;
   localparam int NUM_PREG  = 32;

   // derived field widths
   localparam int LREG_W    = $clog2(NUM_LREG);
   localparam int PREG_W    = $clog2(NUM_PREG);
   localparam int SLOT_W    = $clog2(ISQ_DEPTH);

   //////////////////////////////////////////////////
   // types
   //////////////////////////////////////////////////

   typedef logic [LREG_W-1:0] lreg_t;
   typedef logic [PREG_W-1:0] preg_t;
   typedef logic [SLOT_W-1:0] slot_idx_t;

   // one logical register mapping, rdy set once the value is written back
   typedef struct packed {
      logic  rdy;
      preg_t preg;
   } map_ent_t;

   // entry i holds the mapping of logical register i
   typedef map_ent_t [NUM_LREG-1:0] ren_map_t;

   // instruction as held in one issue queue slot
   typedef struct packed {
      logic  vld;
      logic  wat;
      logic  src1_vld;
      lreg_t lsrc1;
      logic  src2_vld;
      lreg_t lsrc2;
      logic  dst_vld;
      lreg_t ldst;
      preg_t pdest;
   } isq_inst_t;

   // renamed view of one slot
   // fields are zero unless their own valid bit is set
   typedef struct packed {
      logic     vld;
      logic     inst_rdy;
      logic     src1_vld;
      map_ent_t psrc1;
      logic     src2_vld;
      map_ent_t psrc2;
      logic     dst_vld;
      preg_t    pdest;
      preg_t    fre_preg;
   } ren_out_t;

   typedef ren_out_t [ISQ_DEPTH-1:0] ren_out_vec_t;

   //////////////////////////////////////////////////
   // reset map
   //////////////////////////////////////////////////

   // identity mapping, every entry ready
   function automatic ren_map_t reset_map_f();
      ren_map_t map;
      for (int i = 0; i < NUM_LREG; i++)
      begin
         map[i].rdy  = 1'b1;
         map[i].preg = preg_t'(i);
      end
      return map;
   endfunction

   localparam ren_map_t RESET_MAP = reset_map_f();

endpackage
